// ==== flist.f ====
+incdir+src
+incdir+tb
src/isa_pkg.sv
src/ctrl_pkg.sv
src/imm_gen.sv
src/inst_match.sv
src/decode_out_stage.sv
src/decoder_top.sv
tb/decoder_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decoder testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module decoder_tb -o decoder_sim \
    && ./obj_dir/decoder_sim | tee /dev/stderr | grep -q "Test passed" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== src/ctrl_pkg.sv ====
`include "decoder_consts.svh"

package ctrl_pkg;

    import isa_pkg::*;

    typedef logic [`ALU_OP_W-1:0]   alu_op_t;
    typedef logic [`SEL_W-1:0]      opnum1_sel_t;
    typedef logic [`SEL_W-1:0]      opnum2_sel_t;
    // bit 1 memory, bit 0 alu
    typedef logic [1:0]             regin_sel_t;
    typedef logic [7:0]             mem_wstrb_t;
    // bit 8 signed read
    typedef logic [8:0]             mem_rstrb_t;
    // beq at bit 0 up to bgeu at bit 5
    typedef logic [5:0]             br_cond_t;
    // bit 1 jalr, bit 0 sequential
    typedef logic [1:0]             dnpc_sel_t;

    ////////////////////
    // combinational match result
    ////////////////////
    typedef struct packed {
        reg_addr_t      rs1;
        reg_addr_t      rs2;
        reg_addr_t      rd;
        logic           reg_wen;
        regin_sel_t     regin_sel;
        logic           mem_wen;
        mem_wstrb_t     mem_wstrb;
        mem_rstrb_t     mem_rstrb;
        alu_op_t        alu_op;
        opnum1_sel_t    opnum1_sel;
        opnum2_sel_t    opnum2_sel;
        logic           word_op;
        br_cond_t       br_cond;
        logic           jal;
        logic           jalr;
    } match_t;

    ////////////////////
    // registered control bundle
    ////////////////////
    typedef struct packed {
        reg_addr_t      rs1;
        reg_addr_t      rs2;
        reg_addr_t      rd;
        xlen_t          imm;
        logic           reg_wen;
        regin_sel_t     regin_sel;
        logic           mem_wen;
        mem_wstrb_t     mem_wstrb;
        mem_rstrb_t     mem_rstrb;
        alu_op_t        alu_op;
        opnum1_sel_t    opnum1_sel;
        opnum2_sel_t    opnum2_sel;
        logic           word_op;
        dnpc_sel_t      dnpc_sel;
    } ctrl_t;

endpackage

// ==== src/decode_out_stage.sv ====
`timescale 1ns/1ps
`include "decoder_consts.svh"

module decode_out_stage import isa_pkg::*, ctrl_pkg::*; (
    input  logic    sys_clk,
    input  logic    rst_n,
    input  logic    inst_valid,
    input  xlen_t   imm,
    input  match_t  match,
    input  xlen_t   rs1_data,
    input  xlen_t   rs2_data,
    output logic    ctrl_valid,
    output ctrl_t   ctrl
);

    logic           eq;
    logic           lt;
    logic           ltu;
    logic           br_taken;
    br_cond_t       cond_true;
    dnpc_sel_t      dnpc_sel;
    ctrl_t          ctrl_next;

    ////////////////////
    // branch resolution
    ////////////////////
    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data);

    // same bit order as br_cond: bgeu .. beq
    assign cond_true = {~ltu, ltu, ~lt, lt, ~eq, eq};
    assign br_taken  = |(match.br_cond & cond_true);

    // jal and taken branch leave both bits low, i.e. pc+imm
    assign dnpc_sel = ({2{match.jalr}} & `DNPC_JALR)
                    | ({2{~(match.jal | match.jalr | br_taken)}} & `DNPC_SEQ);

    always_comb begin
        ctrl_next.rs1        = match.rs1;
        ctrl_next.rs2        = match.rs2;
        ctrl_next.rd         = match.rd;
        ctrl_next.imm        = imm;
        ctrl_next.reg_wen    = match.reg_wen;
        ctrl_next.regin_sel  = match.regin_sel;
        ctrl_next.mem_wen    = match.mem_wen;
        ctrl_next.mem_wstrb  = match.mem_wstrb;
        ctrl_next.mem_rstrb  = match.mem_rstrb;
        ctrl_next.alu_op     = match.alu_op;
        ctrl_next.opnum1_sel = match.opnum1_sel;
        ctrl_next.opnum2_sel = match.opnum2_sel;
        ctrl_next.word_op    = match.word_op;
        ctrl_next.dnpc_sel   = dnpc_sel;
    end

    ////////////////////
    // output register
    ////////////////////
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            ctrl_valid <= 1'b0;
            ctrl       <= '0;
        end else begin
            ctrl_valid <= inst_valid;
            // bundle holds until the next valid instruction
            if (inst_valid) begin
                ctrl <= ctrl_next;
            end
        end
    end

    assert property (@(posedge sys_clk) !rst_n |=> !ctrl_valid);

    // decode never asks for both a register and a memory write
    assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(ctrl.reg_wen && ctrl.mem_wen));

    assert property (@(posedge sys_clk) disable iff (!rst_n)
        ctrl.dnpc_sel != 2'b11);

endmodule

// ==== src/decoder_consts.svh ====
`ifndef DECODER_CONSTS_SVH
`define DECODER_CONSTS_SVH

// data and field widths
`define XLEN            64
`define ALU_OP_W        10
`define SEL_W           3

////////////////////
// major opcodes
////////////////////
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_OP_IMM      7'b0010011
`define OPC_OP_IMM_32   7'b0011011
`define OPC_OP          7'b0110011
`define OPC_OP_32       7'b0111011

// funct7, base and alternate (sub, sra)
`define F7_BASE         7'b0000000
`define F7_ALT          7'b0100000

////////////////////
// one-hot ALU ops
////////////////////
`define ALU_ADD         10'b00_0000_0001
`define ALU_SUB         10'b00_0000_0010
`define ALU_SLT         10'b00_0000_0100
`define ALU_SLTU        10'b00_0000_1000
`define ALU_XOR         10'b00_0001_0000
`define ALU_OR          10'b00_0010_0000
`define ALU_AND         10'b00_0100_0000
`define ALU_SLL         10'b00_1000_0000
`define ALU_SRL         10'b01_0000_0000
`define ALU_SRA         10'b10_0000_0000

// operand selects
`define OP1_RS1         3'b001
`define OP1_PC          3'b010
`define OP1_ZERO        3'b100
`define OP2_RS2         3'b001
`define OP2_IMM         3'b010
`define OP2_FOUR        3'b100

// byte strobes per access size
`define STRB_D          8'hff
`define STRB_W          8'h0f
`define STRB_H          8'h03
`define STRB_B          8'h01

// next-pc select
`define DNPC_JALR       2'b10
`define DNPC_SEQ        2'b01

`endif

// ==== src/decoder_top.sv ====
`timescale 1ns/1ps

module decoder_top import isa_pkg::*, ctrl_pkg::*; (
    input  logic    sys_clk,
    input  logic    rst_n,
    input  logic    inst_valid,
    input  inst_t   inst,
    input  xlen_t   rs1_data,
    input  xlen_t   rs2_data,
    output logic    ctrl_valid,
    output ctrl_t   ctrl
);

    xlen_t          imm;
    match_t         match;

    // both decoders see the raw instruction in parallel
    imm_gen u_imm_gen (
        .inst       (inst),
        .imm        (imm)
    );

    inst_match u_inst_match (
        .inst       (inst),
        .match      (match)
    );

    // branch compare and register stage
    decode_out_stage u_decode_out_stage (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .imm        (imm),
        .match      (match),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl)
    );

endmodule

// ==== src/imm_gen.sv ====
`timescale 1ns/1ps
`include "decoder_consts.svh"

module imm_gen import isa_pkg::*; (
    input  inst_t   inst,
    output xlen_t   imm
);

    opcode_t        opcode;
    logic           type_i;
    logic           type_s;
    logic           type_b;
    logic           type_u;
    logic           type_j;
    logic [11:0]    imm_i;
    logic [11:0]    imm_s;
    logic [12:0]    imm_b;
    logic [31:0]    imm_u;
    logic [20:0]    imm_j;

    assign opcode = inst[6:0];

    // format from the major opcode only
    assign type_i = (opcode == `OPC_JALR) || (opcode == `OPC_LOAD)
                 || (opcode == `OPC_OP_IMM) || (opcode == `OPC_OP_IMM_32);
    assign type_s = (opcode == `OPC_STORE);
    assign type_b = (opcode == `OPC_BRANCH);
    assign type_u = (opcode == `OPC_LUI) || (opcode == `OPC_AUIPC);
    assign type_j = (opcode == `OPC_JAL);

    // scattered immediate bits
    assign imm_i = inst[31:20];
    assign imm_s = {inst[31:25], inst[11:7]};
    assign imm_b = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        if (type_i) begin
            imm = {{(`XLEN-12){imm_i[11]}}, imm_i};
        end else if (type_s) begin
            imm = {{(`XLEN-12){imm_s[11]}}, imm_s};
        end else if (type_b) begin
            imm = {{(`XLEN-13){imm_b[12]}}, imm_b};
        end else if (type_u) begin
            imm = {{(`XLEN-32){imm_u[31]}}, imm_u};
        end else if (type_j) begin
            imm = {{(`XLEN-21){imm_j[20]}}, imm_j};
        end else begin
            // r-type and unknown
            imm = '0;
        end
    end

endmodule

// ==== src/inst_match.sv ====
`timescale 1ns/1ps
`include "decoder_consts.svh"

module inst_match import isa_pkg::*, ctrl_pkg::*; (
    input  inst_t   inst,
    output match_t  match
);

    opcode_t        opcode;
    funct3_t        funct3;
    funct7_t        funct7;
    logic           is_lui;
    logic           is_auipc;
    logic           is_jal;
    logic           is_jalr;
    logic           is_branch;
    logic           is_load;
    logic           is_store;
    logic           is_op_imm;
    logic           is_op_imm_32;
    logic           is_op;
    logic           is_op_32;
    logic           shift_base;
    logic           shift_alt;
    logic           jalr_ok;
    logic           load_ok;
    logic           store_ok;
    logic           branch_ok;
    logic           i_ok;
    logic           r_ok;
    logic           reg_wen;
    logic           add_fixed;
    alu_op_t        alu_i;
    alu_op_t        alu_r;
    mem_rstrb_t     rstrb;
    mem_wstrb_t     wstrb;
    br_cond_t       br_cond;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign is_lui       = (opcode == `OPC_LUI);
    assign is_auipc     = (opcode == `OPC_AUIPC);
    assign is_jal       = (opcode == `OPC_JAL);
    assign is_jalr      = (opcode == `OPC_JALR);
    assign is_branch    = (opcode == `OPC_BRANCH);
    assign is_load      = (opcode == `OPC_LOAD);
    assign is_store     = (opcode == `OPC_STORE);
    assign is_op_imm    = (opcode == `OPC_OP_IMM);
    assign is_op_imm_32 = (opcode == `OPC_OP_IMM_32);
    assign is_op        = (opcode == `OPC_OP);
    assign is_op_32     = (opcode == `OPC_OP_32);

    // rv64 shamt is 6 bits, so inst[25] is not part of funct7 there
    assign shift_base = (is_op_imm && ({funct7[6:1], 1'b0} == `F7_BASE))
                     || (is_op_imm_32 && (funct7 == `F7_BASE));
    assign shift_alt  = (is_op_imm && ({funct7[6:1], 1'b0} == `F7_ALT))
                     || (is_op_imm_32 && (funct7 == `F7_ALT));

    ////////////////////
    // alu op, immediate forms
    ////////////////////
    always_comb begin
        alu_i = '0;
        if (is_op_imm || is_op_imm_32) begin
            case (funct3)
                3'b000:  alu_i = `ALU_ADD;
                3'b001:  alu_i = shift_base ? `ALU_SLL : '0;
                3'b010:  alu_i = is_op_imm ? `ALU_SLT : '0;
                3'b011:  alu_i = is_op_imm ? `ALU_SLTU : '0;
                3'b100:  alu_i = is_op_imm ? `ALU_XOR : '0;
                3'b101:  alu_i = shift_base ? `ALU_SRL : (shift_alt ? `ALU_SRA : '0);
                3'b110:  alu_i = is_op_imm ? `ALU_OR : '0;
                default: alu_i = is_op_imm ? `ALU_AND : '0;
            endcase
        end
    end

    // register forms, the w opcode only has add/sub and shifts
    always_comb begin
        alu_r = '0;
        if ((is_op || is_op_32) && ((funct7 == `F7_BASE) || (funct7 == `F7_ALT))) begin
            case ({funct7 == `F7_ALT, funct3})
                4'b0_000: alu_r = `ALU_ADD;
                4'b1_000: alu_r = `ALU_SUB;
                4'b0_001: alu_r = `ALU_SLL;
                4'b0_010: alu_r = is_op ? `ALU_SLT : '0;
                4'b0_011: alu_r = is_op ? `ALU_SLTU : '0;
                4'b0_100: alu_r = is_op ? `ALU_XOR : '0;
                4'b0_101: alu_r = `ALU_SRL;
                4'b1_101: alu_r = `ALU_SRA;
                4'b0_110: alu_r = is_op ? `ALU_OR : '0;
                4'b0_111: alu_r = is_op ? `ALU_AND : '0;
                default:  alu_r = '0;
            endcase
        end
    end

    ////////////////////
    // memory strobes and branch kind
    ////////////////////
    always_comb begin
        rstrb = '0;
        wstrb = '0;
        br_cond = '0;
        if (is_load) begin
            case (funct3)
                3'b011:  rstrb = {1'b0, `STRB_D};
                3'b010:  rstrb = {1'b1, `STRB_W};
                3'b110:  rstrb = {1'b0, `STRB_W};
                3'b001:  rstrb = {1'b1, `STRB_H};
                3'b101:  rstrb = {1'b0, `STRB_H};
                3'b000:  rstrb = {1'b1, `STRB_B};
                3'b100:  rstrb = {1'b0, `STRB_B};
                default: rstrb = '0;
            endcase
        end
        if (is_store) begin
            case (funct3)
                3'b011:  wstrb = `STRB_D;
                3'b010:  wstrb = `STRB_W;
                3'b001:  wstrb = `STRB_H;
                3'b000:  wstrb = `STRB_B;
                default: wstrb = '0;
            endcase
        end
        if (is_branch) begin
            case (funct3)
                3'b000:  br_cond = 6'b000001;
                3'b001:  br_cond = 6'b000010;
                3'b100:  br_cond = 6'b000100;
                3'b101:  br_cond = 6'b001000;
                3'b110:  br_cond = 6'b010000;
                3'b111:  br_cond = 6'b100000;
                default: br_cond = '0;
            endcase
        end
    end

    // valid instruction classes
    assign jalr_ok   = is_jalr && (funct3 == 3'b000);
    assign load_ok   = |rstrb[7:0];
    assign store_ok  = |wstrb;
    assign branch_ok = |br_cond;
    assign i_ok      = |alu_i;
    assign r_ok      = |alu_r;
    assign reg_wen   = is_lui | is_auipc | is_jal | jalr_ok | load_ok | i_ok | r_ok;
    // address and link arithmetic all go through the adder
    assign add_fixed = is_lui | is_auipc | is_jal | jalr_ok | load_ok | store_ok | branch_ok;

    always_comb begin
        match.rs1        = inst[19:15];
        match.rs2        = inst[24:20];
        match.rd         = inst[11:7];
        match.reg_wen    = reg_wen;
        match.regin_sel  = {reg_wen & load_ok, reg_wen & ~load_ok};
        match.mem_wen    = store_ok;
        match.mem_wstrb  = wstrb;
        match.mem_rstrb  = rstrb;
        match.alu_op     = alu_i | alu_r | ({`ALU_OP_W{add_fixed}} & `ALU_ADD);
        match.opnum1_sel = ({`SEL_W{is_lui}} & `OP1_ZERO)
                         | ({`SEL_W{is_auipc | is_jal | jalr_ok | branch_ok}} & `OP1_PC)
                         | ({`SEL_W{load_ok | store_ok | i_ok | r_ok}} & `OP1_RS1);
        match.opnum2_sel = ({`SEL_W{is_jal | jalr_ok}} & `OP2_FOUR)
                         | ({`SEL_W{r_ok}} & `OP2_RS2)
                         | ({`SEL_W{is_lui | is_auipc | load_ok | store_ok | branch_ok | i_ok}}
                            & `OP2_IMM);
        match.word_op    = (is_op_imm_32 & i_ok) | (is_op_32 & r_ok);
        match.br_cond    = br_cond;
        match.jal        = is_jal;
        match.jalr       = jalr_ok;
    end

    // the class flags above must stay mutually exclusive
    always_comb begin
        assert ($onehot0(match.alu_op) && $onehot0(match.opnum1_sel)
                && $onehot0(match.opnum2_sel))
            else $error("inst_match: select not one-hot for inst %h", inst);
    end

endmodule

// ==== src/isa_pkg.sv ====
`include "decoder_consts.svh"

package isa_pkg;

    // raw instruction word and its fields
    typedef logic [31:0]        inst_t;
    typedef logic [6:0]         opcode_t;
    typedef logic [2:0]         funct3_t;
    typedef logic [6:0]         funct7_t;
    typedef logic [4:0]         reg_addr_t;

    // register values and immediates
    typedef logic [`XLEN-1:0]   xlen_t;

endpackage

// ==== tb/decode_vectors.svh ====
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// columns: name, instruction, rs1 data, rs2 data, expected bundle
// rows without data columns get random register values
task automatic build_table();
    ////////////////////
    // register forms
    ////////////////////
    random_data_entry("add",  r_word(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, 7'h33), r_bundle(10'h001, 0));
    random_data_entry("sub",  r_word(7'h20, 5'd4, 5'd5, 3'd0, 5'd6, 7'h33), r_bundle(10'h002, 0));
    random_data_entry("sll",  r_word(7'h00, 5'd7, 5'd8, 3'd1, 5'd9, 7'h33), r_bundle(10'h080, 0));
    random_data_entry("slt",  r_word(7'h00, 5'd10, 5'd11, 3'd2, 5'd12, 7'h33),
                      r_bundle(10'h004, 0));
    random_data_entry("sltu", r_word(7'h00, 5'd13, 5'd14, 3'd3, 5'd15, 7'h33),
                      r_bundle(10'h008, 0));
    random_data_entry("xor",  r_word(7'h00, 5'd16, 5'd17, 3'd4, 5'd18, 7'h33),
                      r_bundle(10'h010, 0));
    random_data_entry("srl",  r_word(7'h00, 5'd19, 5'd20, 3'd5, 5'd21, 7'h33),
                      r_bundle(10'h100, 0));
    random_data_entry("sra",  r_word(7'h20, 5'd22, 5'd23, 3'd5, 5'd24, 7'h33),
                      r_bundle(10'h200, 0));
    random_data_entry("or",   r_word(7'h00, 5'd25, 5'd26, 3'd6, 5'd27, 7'h33),
                      r_bundle(10'h020, 0));
    random_data_entry("and",  r_word(7'h00, 5'd28, 5'd29, 3'd7, 5'd30, 7'h33),
                      r_bundle(10'h040, 0));
    random_data_entry("addw", r_word(7'h00, 5'd31, 5'd1, 3'd0, 5'd2, 7'h3b), r_bundle(10'h001, 1));
    random_data_entry("subw", r_word(7'h20, 5'd3, 5'd4, 3'd0, 5'd5, 7'h3b), r_bundle(10'h002, 1));
    random_data_entry("sllw", r_word(7'h00, 5'd6, 5'd7, 3'd1, 5'd8, 7'h3b), r_bundle(10'h080, 1));
    random_data_entry("srlw", r_word(7'h00, 5'd9, 5'd10, 3'd5, 5'd11, 7'h3b),
                      r_bundle(10'h100, 1));
    random_data_entry("sraw", r_word(7'h20, 5'd12, 5'd13, 3'd5, 5'd14, 7'h3b),
                      r_bundle(10'h200, 1));

    ////////////////////
    // immediate forms
    ////////////////////
    random_data_entry("addi",  i_word(12'hffb, 5'd3, 3'd0, 5'd7, 7'h13),
                      i_bundle(64'hffff_ffff_ffff_fffb, 10'h001, 0));
    random_data_entry("slti",  i_word(12'h07f, 5'd4, 3'd2, 5'd8, 7'h13),
                      i_bundle(64'h7f, 10'h004, 0));
    random_data_entry("sltiu", i_word(12'h800, 5'd5, 3'd3, 5'd9, 7'h13),
                      i_bundle(64'hffff_ffff_ffff_f800, 10'h008, 0));
    random_data_entry("xori",  i_word(12'hfff, 5'd6, 3'd4, 5'd10, 7'h13),
                      i_bundle(64'hffff_ffff_ffff_ffff, 10'h010, 0));
    random_data_entry("ori",   i_word(12'h123, 5'd7, 3'd6, 5'd11, 7'h13),
                      i_bundle(64'h123, 10'h020, 0));
    random_data_entry("andi",  i_word(12'h0f0, 5'd8, 3'd7, 5'd12, 7'h13),
                      i_bundle(64'hf0, 10'h040, 0));
    random_data_entry("slli",  i_word(12'h03f, 5'd9, 3'd1, 5'd13, 7'h13),
                      i_bundle(64'h3f, 10'h080, 0));
    random_data_entry("srli",  i_word(12'h021, 5'd10, 3'd5, 5'd14, 7'h13),
                      i_bundle(64'h21, 10'h100, 0));
    random_data_entry("srai",  i_word(12'h42a, 5'd11, 3'd5, 5'd15, 7'h13),
                      i_bundle(64'h42a, 10'h200, 0));
    random_data_entry("addiw", i_word(12'hf9c, 5'd12, 3'd0, 5'd16, 7'h1b),
                      i_bundle(64'hffff_ffff_ffff_ff9c, 10'h001, 1));
    random_data_entry("slliw", i_word(12'h01f, 5'd13, 3'd1, 5'd17, 7'h1b),
                      i_bundle(64'h1f, 10'h080, 1));
    random_data_entry("srliw", i_word(12'h005, 5'd14, 3'd5, 5'd18, 7'h1b),
                      i_bundle(64'h5, 10'h100, 1));
    random_data_entry("sraiw", i_word(12'h40c, 5'd15, 3'd5, 5'd19, 7'h1b),
                      i_bundle(64'h40c, 10'h200, 1));

    // loads and stores
    random_data_entry("ld",  i_word(12'h010, 5'd2, 3'd3, 5'd20, 7'h03),
                      load_bundle(64'h10, 9'h0ff));
    random_data_entry("lw",  i_word(12'h010, 5'd2, 3'd2, 5'd21, 7'h03),
                      load_bundle(64'h10, 9'h10f));
    random_data_entry("lwu", i_word(12'h010, 5'd2, 3'd6, 5'd22, 7'h03),
                      load_bundle(64'h10, 9'h00f));
    random_data_entry("lh",  i_word(12'h010, 5'd2, 3'd1, 5'd23, 7'h03),
                      load_bundle(64'h10, 9'h103));
    random_data_entry("lhu", i_word(12'h010, 5'd2, 3'd5, 5'd24, 7'h03),
                      load_bundle(64'h10, 9'h003));
    random_data_entry("lb",  i_word(12'h800, 5'd2, 3'd0, 5'd25, 7'h03),
                      load_bundle(64'hffff_ffff_ffff_f800, 9'h101));
    random_data_entry("lbu", i_word(12'h010, 5'd2, 3'd4, 5'd26, 7'h03),
                      load_bundle(64'h10, 9'h001));
    random_data_entry("sd", s_word(12'h018, 5'd5, 5'd2, 3'd3), store_bundle(64'h18, 8'hff));
    random_data_entry("sw", s_word(12'hff8, 5'd6, 5'd2, 3'd2),
                      store_bundle(64'hffff_ffff_ffff_fff8, 8'h0f));
    random_data_entry("sh", s_word(12'h018, 5'd7, 5'd2, 3'd1), store_bundle(64'h18, 8'h03));
    random_data_entry("sb", s_word(12'h018, 5'd8, 5'd2, 3'd0), store_bundle(64'h18, 8'h01));

    ////////////////////
    // branches, taken and not taken
    ////////////////////
    append_entry("beq taken", b_word(13'h1ff0, 5'd2, 5'd1, 3'd0), 64'h1234, 64'h1234,
                 branch_bundle(64'hffff_ffff_ffff_fff0, 2'b00));
    append_entry("beq not taken", b_word(13'h1ff0, 5'd2, 5'd1, 3'd0), 64'h1234, 64'h1235,
                 branch_bundle(64'hffff_ffff_ffff_fff0, 2'b01));
    append_entry("bne taken", b_word(13'h0ffe, 5'd4, 5'd3, 3'd1), 64'h5, 64'h6,
                 branch_bundle(64'hffe, 2'b00));
    append_entry("bne not taken", b_word(13'h0ffe, 5'd4, 5'd3, 3'd1), 64'h7, 64'h7,
                 branch_bundle(64'hffe, 2'b01));
    append_entry("blt taken", b_word(13'h0010, 5'd6, 5'd5, 3'd4), '1, 64'h1,
                 branch_bundle(64'h10, 2'b00));
    append_entry("blt not taken", b_word(13'h0010, 5'd6, 5'd5, 3'd4), 64'h1, '1,
                 branch_bundle(64'h10, 2'b01));
    append_entry("bge taken", b_word(13'h0010, 5'd8, 5'd7, 3'd5), 64'h1, '1,
                 branch_bundle(64'h10, 2'b00));
    append_entry("bge not taken", b_word(13'h0010, 5'd8, 5'd7, 3'd5), '1, 64'h1,
                 branch_bundle(64'h10, 2'b01));
    append_entry("bltu taken", b_word(13'h0010, 5'd10, 5'd9, 3'd6), 64'h1, '1,
                 branch_bundle(64'h10, 2'b00));
    append_entry("bltu not taken", b_word(13'h0010, 5'd10, 5'd9, 3'd6), '1, 64'h1,
                 branch_bundle(64'h10, 2'b01));
    append_entry("bgeu taken", b_word(13'h0010, 5'd12, 5'd11, 3'd7), '1, 64'h1,
                 branch_bundle(64'h10, 2'b00));
    append_entry("bgeu not taken", b_word(13'h0010, 5'd12, 5'd11, 3'd7), 64'h1, '1,
                 branch_bundle(64'h10, 2'b01));

    // upper immediates, jumps and junk
    random_data_entry("lui", u_word(20'h80001, 5'd10, 7'h37),
                      make_bundle(64'hffff_ffff_8000_1000, 1, 2'b01, 0, 8'h00, 9'h000,
                                  10'h001, 3'b100, 3'b010, 0, 2'b01));
    random_data_entry("auipc", u_word(20'h12345, 5'd11, 7'h17),
                      make_bundle(64'h1234_5000, 1, 2'b01, 0, 8'h00, 9'h000,
                                  10'h001, 3'b010, 3'b010, 0, 2'b01));
    random_data_entry("jal", j_word(21'h1abcde, 5'd1),
                      make_bundle(64'hffff_ffff_fffa_bcde, 1, 2'b01, 0, 8'h00, 9'h000,
                                  10'h001, 3'b010, 3'b100, 0, 2'b00));
    random_data_entry("jalr", i_word(12'h7ff, 5'd5, 3'd0, 5'd1, 7'h67),
                      make_bundle(64'h7ff, 1, 2'b01, 0, 8'h00, 9'h000,
                                  10'h001, 3'b010, 3'b100, 0, 2'b10));
    random_data_entry("unknown 7f", 32'hdead_be7f,
                      make_bundle('0, 0, 2'b00, 0, 8'h00, 9'h000, 10'h000, 3'b000, 3'b000,
                                  0, 2'b01));
    random_data_entry("all zero", 32'h0000_0000,
                      make_bundle('0, 0, 2'b00, 0, 8'h00, 9'h000, 10'h000, 3'b000, 3'b000,
                                  0, 2'b01));
    random_data_entry("add again", r_word(7'h00, 5'd31, 5'd30, 3'd0, 5'd29, 7'h33),
                      r_bundle(10'h001, 0));
endtask

`endif

// ==== tb/decoder_tb.sv ====
`timescale 1ns/1ps

module decoder_tb import isa_pkg::*, ctrl_pkg::*;;

    logic           sys_clk;
    logic           rst_n;
    logic           inst_valid;
    inst_t          inst;
    xlen_t          rs1_data;
    xlen_t          rs2_data;
    logic           ctrl_valid;
    ctrl_t          ctrl;

    // stimulus table
    string          names[$];
    inst_t          insts[$];
    xlen_t          data1[$];
    xlen_t          data2[$];
    ctrl_t          exps[$];
    int             cycles;
    int             limit;

    decoder_top u_decoder_top (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl)
    );

    always #20 sys_clk = ~sys_clk;

    ////////////////////
    // instruction encoders
    ////////////////////
    function automatic inst_t r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic inst_t b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic inst_t u_word(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic inst_t j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    ////////////////////
    // expected bundles per class
    ////////////////////
    function automatic ctrl_t make_bundle(input xlen_t imm, input logic wen,
                                          input regin_sel_t regin, input logic mwen,
                                          input mem_wstrb_t ws, input mem_rstrb_t rs,
                                          input alu_op_t alu, input opnum1_sel_t op1,
                                          input opnum2_sel_t op2, input logic word,
                                          input dnpc_sel_t dnpc);
        ctrl_t b;
        b = '0;
        b.imm        = imm;
        b.reg_wen    = wen;
        b.regin_sel  = regin;
        b.mem_wen    = mwen;
        b.mem_wstrb  = ws;
        b.mem_rstrb  = rs;
        b.alu_op     = alu;
        b.opnum1_sel = op1;
        b.opnum2_sel = op2;
        b.word_op    = word;
        b.dnpc_sel   = dnpc;
        return b;
    endfunction

    function automatic ctrl_t r_bundle(input alu_op_t alu, input logic word);
        return make_bundle('0, 1, 2'b01, 0, 8'h00, 9'h000, alu, 3'b001, 3'b001, word, 2'b01);
    endfunction

    function automatic ctrl_t i_bundle(input xlen_t imm, input alu_op_t alu, input logic word);
        return make_bundle(imm, 1, 2'b01, 0, 8'h00, 9'h000, alu, 3'b001, 3'b010, word, 2'b01);
    endfunction

    function automatic ctrl_t load_bundle(input xlen_t imm, input mem_rstrb_t rs);
        return make_bundle(imm, 1, 2'b10, 0, 8'h00, rs, 10'h001, 3'b001, 3'b010, 0, 2'b01);
    endfunction

    function automatic ctrl_t store_bundle(input xlen_t imm, input mem_wstrb_t ws);
        return make_bundle(imm, 0, 2'b00, 1, ws, 9'h000, 10'h001, 3'b001, 3'b010, 0, 2'b01);
    endfunction

    // branches compute the target from pc and imm
    function automatic ctrl_t branch_bundle(input xlen_t imm, input dnpc_sel_t dnpc);
        return make_bundle(imm, 0, 2'b00, 0, 8'h00, 9'h000, 10'h001, 3'b010, 3'b010, 0, dnpc);
    endfunction

    // register fields always come straight from the encoding
    task automatic append_entry(input string name, input inst_t i, input xlen_t d1,
                                input xlen_t d2, input ctrl_t e);
        ctrl_t full;
        full = e;
        full.rs1 = i[19:15];
        full.rs2 = i[24:20];
        full.rd  = i[11:7];
        names.push_back(name);
        insts.push_back(i);
        data1.push_back(d1);
        data2.push_back(d2);
        exps.push_back(full);
    endtask

    task automatic random_data_entry(input string name, input inst_t i, input ctrl_t e);
        append_entry(name, i, {$urandom, $urandom}, {$urandom, $urandom}, e);
    endtask

    `include "decode_vectors.svh"

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_idle(input string when);
        assert (ctrl_valid == 1'b0)
            else fail_run($sformatf("error: %s ctrl_valid expected 0 actual %b",
                                    when, ctrl_valid));
        assert (ctrl == '0)
            else fail_run($sformatf("error: %s expected %h actual %h", when, ctrl_t'('0), ctrl));
    endtask

    task automatic check_entry(input int k);
        assert (ctrl_valid == 1'b1)
            else fail_run($sformatf("error: %s ctrl_valid expected 1 actual %b",
                                    names[k], ctrl_valid));
        assert (ctrl == exps[k])
            else fail_run($sformatf("error: %s expected %h actual %h", names[k], exps[k], ctrl));
    endtask

    // run limit from the table length
    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            fail_run("timeout: decoder never finished the table");
        end
    end

    initial begin
        int n;
        void'($urandom(84));
        sys_clk    = 1'b0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        rs1_data   = '0;
        rs2_data   = '0;
        cycles     = 0;
        limit      = 0;
        build_table();
        n = names.size();
        limit = 8 + 2 * n + 20;

        // a live instruction during reset must not reach the outputs
        inst_valid = 1'b1;
        inst       = insts[0];
        rs1_data   = data1[0];
        rs2_data   = data2[0];

        repeat (8) begin
            @(posedge sys_clk);
            #1;
            check_idle("during reset");
        end
        rst_n      = 1'b1;
        inst_valid = 1'b0;
        @(posedge sys_clk);
        #1;
        check_idle("after reset");

        ////////////////////
        // one entry per cycle, checked one cycle later
        ////////////////////
        for (int k = 0; k < n; k++) begin
            inst_valid = 1'b1;
            inst       = insts[k];
            rs1_data   = data1[k];
            rs2_data   = data2[k];
            @(posedge sys_clk);
            #1;
            check_entry(k);
        end

        // a different word while idle must leave the bundle alone
        inst_valid = 1'b0;
        inst       = insts[0];
        rs1_data   = data1[0];
        rs2_data   = data2[0];
        @(posedge sys_clk);
        #1;
        assert (ctrl_valid == 1'b0)
            else fail_run($sformatf("error: idle ctrl_valid expected 0 actual %b", ctrl_valid));
        // bundle holds while nothing new arrives
        assert (ctrl == exps[n - 1])
            else fail_run($sformatf("error: hold expected %h actual %h", exps[n - 1], ctrl));

        $display("Test passed");
        $finish;
    end

endmodule
